// File: tb.f
verilog/lbpPkg.sv
verilog/pixelFifo.sv
verilog/scanCounter.sv
verilog/lbpController.sv
verilog/neighborWindow.sv
verilog/bilinearInterp.sv
verilog/lbpCodeBuilder.sv
verilog/lbpTop.sv
tests/lbpTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lbpTb -f tb.f -o lbpSim

output=$(./obj_dir/lbpSim)
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
    exit 0
else
    exit 1
fi

// File: tests/lbpTb.sv
`default_nettype none

module lbpTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMG_WIDTH   = 16;
    localparam int IMG_HEIGHT  = 12;
    localparam int RADIUS      = 2;
    localparam int FIFO_DEPTH  = 4;
    localparam int MAX_FRAMES  = 2;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 20000;
    localparam int PAT_FLAT    = 0;
    localparam int PAT_RAMP    = 1;
    localparam int PAT_RANDOM  = 2;
    localparam int CR_FREE     = 0;
    localparam int CR_HOLD     = 1;
    localparam int CR_SINGLE   = 2;

    typedef struct {
        string name;
        int    pattern;
        int    frames;
        int    credit;
        int    hold;
    } testEntry;

    logic       clk;
    logic       rst_n;
    logic       pixValid;
    logic [7:0] pixData;
    logic       codeCredit;
    logic       pixCredit;
    logic       codeValid;
    logic [7:0] code;
    logic       frameDone;

    logic [7:0]  frame [MAX_FRAMES][IMG_HEIGHT][IMG_WIDTH];
    logic [7:0]  expQ [$];
    logic [31:0] lcgState;
    testEntry    tests [NUM_TESTS];
    int          errors;
    int          testsFailed;
    int          testsRun;
    bit          hung;

    lbpTop #(
        .IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT),
        .RADIUS(RADIUS), .FIFO_DEPTH(FIFO_DEPTH)
    ) lbpTop_inst (
        .clk, .rst_n, .pixValid, .pixData, .codeCredit,
        .pixCredit, .codeValid, .code, .frameDone
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [7:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:24];   // Upper bits have the longest period.
    endfunction

    // Floor of r*cos45, the offset of the cell corner nearest the centre.
    function automatic int diagFloor(input int r);
        int f;
        f = 0;
        while (2 * (f + 1) * (f + 1) <= r * r) begin
            f++;
        end
        return f;
    endfunction

    // ******************************
    // Reference model.
    // ******************************
    function automatic logic [7:0] interpSample(input int f, input int cx, input int cy,
                                                input lbpPkg::diagAngle ang);
        int          fl;
        int          x0;
        int          y0;
        logic [31:0] acc;
        fl = diagFloor(RADIUS);
        // Top-left corner of the 2x2 cell; rows grow downwards, north is up.
        x0 = (ang == lbpPkg::ANG45 || ang == lbpPkg::ANG315) ? cx + fl : cx - fl - 1;
        y0 = (ang == lbpPkg::ANG225 || ang == lbpPkg::ANG315) ? cy + fl : cy - fl - 1;
        acc = 32'(lbpPkg::weightOf(RADIUS, ang, 0)) * 32'(frame[f][y0][x0])
            + 32'(lbpPkg::weightOf(RADIUS, ang, 1)) * 32'(frame[f][y0][x0+1])
            + 32'(lbpPkg::weightOf(RADIUS, ang, 2)) * 32'(frame[f][y0+1][x0])
            + 32'(lbpPkg::weightOf(RADIUS, ang, 3)) * 32'(frame[f][y0+1][x0+1]);
        return acc[23:16];
    endfunction

    function automatic logic [7:0] modelCode(input int f, input int cx, input int cy);
        logic [7:0] s [8];
        logic [7:0] ctr;
        logic [7:0] c;
        ctr  = frame[f][cy][cx];
        s[0] = frame[f][cy][cx+RADIUS];
        s[1] = interpSample(f, cx, cy, lbpPkg::ANG45);
        s[2] = frame[f][cy-RADIUS][cx];
        s[3] = interpSample(f, cx, cy, lbpPkg::ANG135);
        s[4] = frame[f][cy][cx-RADIUS];
        s[5] = interpSample(f, cx, cy, lbpPkg::ANG225);
        s[6] = frame[f][cy+RADIUS][cx];
        s[7] = interpSample(f, cx, cy, lbpPkg::ANG315);
        for (int k = 0; k < 8; k++) begin
            c[k] = (s[k] >= ctr);
        end
        return c;
    endfunction

    task automatic prepareTest(input testEntry t);
        for (int f = 0; f < t.frames; f++) begin
            for (int y = 0; y < IMG_HEIGHT; y++) begin
                for (int x = 0; x < IMG_WIDTH; x++) begin
                    case (t.pattern)
                        PAT_FLAT: frame[f][y][x] = 8'(100 + f * 20);
                        PAT_RAMP: frame[f][y][x] = 8'(x * 16 + f * 3);
                        default:  frame[f][y][x] = lcgNext();
                    endcase
                end
            end
        end
        expQ.delete();
        for (int f = 0; f < t.frames; f++) begin
            for (int cy = RADIUS; cy < IMG_HEIGHT - RADIUS; cy++) begin
                for (int cx = RADIUS; cx < IMG_WIDTH - RADIUS; cx++) begin
                    expQ.push_back(modelCode(f, cx, cy));
                end
            end
        end
    endtask

    // ******************************
    // One test: source, sink, checks.
    // ******************************
    task automatic runTest(input int idx, output bit timedOut);
        testEntry   t;
        int         pixTotal;
        int         pixIdx;
        int         srcCredit;
        int         creditPulses;
        int         granted;
        int         received;
        int         dones;
        int         cycle;
        int         mism;
        int         f;
        logic [7:0] expCode;
        bit         done;
        t = tests[idx];
        prepareTest(t);
        pixTotal     = t.frames * IMG_WIDTH * IMG_HEIGHT;
        pixIdx       = 0;
        srcCredit    = FIFO_DEPTH;
        creditPulses = 0;
        granted      = 0;
        received     = 0;
        dones        = 0;
        cycle        = 0;
        mism         = 0;
        done         = 1'b0;
        while (!done && cycle < TEST_CYCLES) begin
            @(posedge clk);
            #2;
            if (pixIdx < pixTotal && srcCredit > 0) begin
                f        = pixIdx / (IMG_WIDTH * IMG_HEIGHT);
                pixValid = 1'b1;
                pixData  = frame[f][(pixIdx / IMG_WIDTH) % IMG_HEIGHT][pixIdx % IMG_WIDTH];
                srcCredit--;
                pixIdx++;
            end else begin
                pixValid = 1'b0;
            end
            codeCredit = 1'b0;
            if (granted < expQ.size()) begin
                case (t.credit)
                    CR_HOLD:   codeCredit = (cycle >= t.hold);
                    CR_SINGLE: codeCredit = (granted == received);   // Only one outstanding.
                    default:   codeCredit = 1'b1;
                endcase
            end
            if (codeCredit) begin
                granted++;
            end
            @(negedge clk);
            if (pixCredit) begin
                creditPulses++;
                srcCredit++;
                assert (srcCredit <= FIFO_DEPTH) else begin
                    $display("%0t: test %0d got more pixel credits than pixels sent", $time, idx);
                    mism++;
                end
            end
            if (codeValid) begin
                assert (received < granted) else begin
                    $display("%0t: test %0d code appeared without a granted credit", $time, idx);
                    mism++;
                end
                assert (received < expQ.size()) else begin
                    $display("%0t: test %0d produced more codes than expected", $time, idx);
                    mism++;
                end
                if (received < expQ.size()) begin
                    expCode = expQ[received];
                    assert (code == expCode) else begin
                        $display("MISMATCH at %0t: test %0d code %0d expected %02h got %02h",
                                 $time, idx, received, expCode, code);
                        mism++;
                    end
                end
                received++;
            end
            if (frameDone) begin
                dones++;
            end
            cycle++;
            done = (received == expQ.size()) && (dones == t.frames) && (creditPulses == pixTotal);
        end
        @(posedge clk);
        #2;
        pixValid   = 1'b0;
        codeCredit = 1'b0;
        timedOut   = !done;
        if (timedOut) begin
            $display("timeout: test %0d stalled after %0d cycles, %0d of %0d codes",
                     idx, cycle, received, expQ.size());
            mism++;
        end else begin
            // Nothing more may leave the DUT once the frames are complete.
            for (int k = 0; k < 12; k++) begin
                @(negedge clk);
                assert (!codeValid && !frameDone) else begin
                    $display("%0t: test %0d DUT output active after the last frame", $time, idx);
                    mism++;
                end
            end
        end
        $display("test %0d %s: %0d of %0d codes, %0d pixel credits, %0d frames, %0d errors",
                 idx, t.name, received, expQ.size(), creditPulses, dones, mism);
        errors += mism;
        testsRun++;
        if (mism != 0) begin
            testsFailed++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        pixValid    = 1'b0;
        pixData     = 8'h00;
        codeCredit  = 1'b0;
        lcgState    = 32'h46ad_1aab;
        errors      = 0;
        testsFailed = 0;
        testsRun    = 0;
        hung        = 1'b0;
        tests[0] = '{"flat", PAT_FLAT, 1, CR_FREE, 0};
        tests[1] = '{"ramp", PAT_RAMP, 1, CR_FREE, 0};
        tests[2] = '{"random", PAT_RANDOM, 1, CR_FREE, 0};
        tests[3] = '{"random, credit held", PAT_RANDOM, 1, CR_HOLD, 200};
        tests[4] = '{"ramp, single credit", PAT_RAMP, 1, CR_SINGLE, 0};
        tests[5] = '{"random, two frames", PAT_RANDOM, 2, CR_FREE, 0};
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            assert (!codeValid && !frameDone && !pixCredit) else begin
                $display("%0t: DUT output active after reset with no input", $time);
                errors++;
            end
        end
        for (int i = 0; i < NUM_TESTS && !hung; i++) begin
            runTest(i, hung);
        end
        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && !hung) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/lbpTop.sv
`default_nettype none

module lbpTop #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 12,
    parameter int RADIUS     = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       pixValid,
    input  wire  [lbpPkg::PIX_W-1:0]  pixData,
    input  wire                       codeCredit,
    output logic                      pixCredit,
    output logic                      codeValid,
    output logic [7:0]                code,
    output logic                      frameDone
);

    logic [lbpPkg::PIX_W-1:0]      headData;
    logic                          notEmpty;
    logic                          pop;
    logic                          interior;
    logic                          lastPixel;
    logic                          popInterior;
    logic [lbpPkg::PIX_W-1:0]      centre, east, north, west, south;
    logic [3:0][lbpPkg::PIX_W-1:0] cellA, cellB, cellC, cellD;
    logic [3:0][lbpPkg::PIX_W-1:0] diag;

    assign popInterior = pop && interior;   // Marks a pop that carries a reserved credit.

    pixelFifo #(.FIFO_DEPTH(FIFO_DEPTH)) pixelFifo_inst (
        .clk, .rst_n, .pixValid, .pixData, .pop,
        .headData, .notEmpty, .pixCredit
    );

    scanCounter #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT), .RADIUS(RADIUS))
    scanCounter_inst (
        .clk, .rst_n, .advance(pop), .interior, .lastPixel
    );

    lbpController lbpController_inst (
        .clk, .rst_n, .notEmpty, .interior, .lastPixel, .codeCredit,
        .pop, .frameDone
    );

    neighborWindow #(.IMG_WIDTH(IMG_WIDTH), .RADIUS(RADIUS)) neighborWindow_inst (
        .clk, .rst_n, .shiftIn(pop), .pixIn(headData),
        .centre, .east, .north, .west, .south,
        .cellA, .cellB, .cellC, .cellD
    );

    // One interpolator per diagonal direction.
    for (genvar a = 0; a < 4; a++) begin : gInterp
        bilinearInterp #(.RADIUS(RADIUS), .ANGLE(lbpPkg::diagAngle'(a))) bilinearInterp_inst (
            .clk, .rst_n,
            .pixA(cellA[a]), .pixB(cellB[a]), .pixC(cellC[a]), .pixD(cellD[a]),
            .sample(diag[a])
        );
    end

    lbpCodeBuilder lbpCodeBuilder_inst (
        .clk, .rst_n, .popInterior,
        .centre, .east, .north, .west, .south, .diag,
        .codeValid, .code
    );

endmodule

`default_nettype wire

// File: verilog/lbpCodeBuilder.sv
`default_nettype none

module lbpCodeBuilder (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              popInterior,
    input  wire  [lbpPkg::PIX_W-1:0]         centre,
    input  wire  [lbpPkg::PIX_W-1:0]         east,
    input  wire  [lbpPkg::PIX_W-1:0]         north,
    input  wire  [lbpPkg::PIX_W-1:0]         west,
    input  wire  [lbpPkg::PIX_W-1:0]         south,
    input  wire  [3:0][lbpPkg::PIX_W-1:0]    diag,
    output logic                             codeValid,
    output logic [7:0]                       code
);

    localparam int VALID_STAGES = 4;
    localparam int DATA_STAGES  = 3;   // The window register is the first of four.

    logic [VALID_STAGES-1:0]       validPipe;
    logic [4:0][lbpPkg::PIX_W-1:0] axialDly [DATA_STAGES];
    logic [4:0][lbpPkg::PIX_W-1:0] tap;
    logic [lbpPkg::PIX_W-1:0]      ctr;
    logic [7:0]                    nextCode;

    assign tap = axialDly[DATA_STAGES-1];
    assign ctr = tap[0];

    // Bit 0 is east, then anticlockwise in 45 degree steps.
    assign nextCode = {diag[lbpPkg::ANG315] >= ctr, tap[4] >= ctr,
                       diag[lbpPkg::ANG225] >= ctr, tap[3] >= ctr,
                       diag[lbpPkg::ANG135] >= ctr, tap[2] >= ctr,
                       diag[lbpPkg::ANG45]  >= ctr, tap[1] >= ctr};

    always_ff @(posedge clk) begin
        axialDly[0] <= {south, west, north, east, centre};
        for (int k = 1; k < DATA_STAGES; k++) begin
            axialDly[k] <= axialDly[k-1];
        end
        code <= nextCode;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            validPipe <= '0;
            codeValid <= 1'b0;
        end else begin
            validPipe <= {validPipe[VALID_STAGES-2:0], popInterior};
            codeValid <= validPipe[VALID_STAGES-1];
        end
    end

endmodule

`default_nettype wire

// File: verilog/bilinearInterp.sv
`default_nettype none

module bilinearInterp #(
    parameter int               RADIUS = 2,
    parameter lbpPkg::diagAngle ANGLE  = lbpPkg::ANG45
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire  [lbpPkg::PIX_W-1:0]  pixA,
    input  wire  [lbpPkg::PIX_W-1:0]  pixB,
    input  wire  [lbpPkg::PIX_W-1:0]  pixC,
    input  wire  [lbpPkg::PIX_W-1:0]  pixD,
    output logic [lbpPkg::PIX_W-1:0]  sample
);

    localparam int W = lbpPkg::WEIGHT_W;

    logic [3:0][lbpPkg::PIX_W-1:0] pix;
    logic [W-1:0]                  weight [4];
    logic [W-1:0]                  product [4];
    logic [W-1:0]                  pairSum [2];
    logic [W-1:0]                  total;

    assign pix = {pixD, pixC, pixB, pixA};

    // Weights are fixed per instance and settle while reset is held.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < 4; k++) begin
                weight[k] <= lbpPkg::weightOf(RADIUS, ANGLE, k);
            end
        end
    end

    // ******************************
    // Multiply, pair add, final add.
    // ******************************
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            product[k] <= W'(weight[k] * pix[k]);   // Weight below 2^16 keeps this in 24 bits.
        end
        pairSum[0] <= product[0] + product[1];
        pairSum[1] <= product[2] + product[3];
        total      <= pairSum[0] + pairSum[1];
    end

    // Integer part of the Q8.16 sum, truncated.
    assign sample = total[W-1 -: lbpPkg::PIX_W];

endmodule

`default_nettype wire

// File: verilog/neighborWindow.sv
`default_nettype none

module neighborWindow #(
    parameter int IMG_WIDTH = 16,
    parameter int RADIUS    = 2
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              shiftIn,
    input  wire  [lbpPkg::PIX_W-1:0]         pixIn,
    output logic [lbpPkg::PIX_W-1:0]         centre,
    output logic [lbpPkg::PIX_W-1:0]         east,
    output logic [lbpPkg::PIX_W-1:0]         north,
    output logic [lbpPkg::PIX_W-1:0]         west,
    output logic [lbpPkg::PIX_W-1:0]         south,
    output logic [3:0][lbpPkg::PIX_W-1:0]    cellA,
    output logic [3:0][lbpPkg::PIX_W-1:0]    cellB,
    output logic [3:0][lbpPkg::PIX_W-1:0]    cellC,
    output logic [3:0][lbpPkg::PIX_W-1:0]    cellD
);

    localparam int LINES = 2 * RADIUS;
    localparam int SPAN  = LINES + 1;
    localparam int PTR_W = $clog2(IMG_WIDTH);
    localparam int FL    = (RADIUS * 181) / 256;   // floor(RADIUS*cos45), 181/256 ~ 0.707.
    localparam int CL    = FL + 1;

    logic [lbpPkg::PIX_W-1:0] lineMem [LINES][IMG_WIDTH];
    logic [PTR_W-1:0]         colPtr;
    logic [lbpPkg::PIX_W-1:0] colIn [SPAN];
    logic [lbpPkg::PIX_W-1:0] win [SPAN][SPAN];

    // ******************************
    // Row buffers and window.
    // ******************************
    // Line j returns the pixel j+1 rows above the incoming one.
    always_comb begin
        colIn[LINES] = pixIn;
        for (int r = 0; r < LINES; r++) begin
            colIn[r] = lineMem[LINES-1-r][colPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            colPtr <= '0;
        end else if (shiftIn) begin
            colPtr <= (colPtr == PTR_W'(IMG_WIDTH - 1)) ? '0 : colPtr + 1'b1;
        end
    end

    // Row 0 of the window is the top, column LINES the newest (east) column.
    always_ff @(posedge clk) begin
        if (shiftIn) begin
            lineMem[0][colPtr] <= pixIn;
            for (int j = 1; j < LINES; j++) begin
                lineMem[j][colPtr] <= lineMem[j-1][colPtr];
            end
            for (int r = 0; r < SPAN; r++) begin
                for (int c = 0; c < LINES; c++) begin
                    win[r][c] <= win[r][c+1];
                end
                win[r][LINES] <= colIn[r];
            end
        end
    end

    assign centre = win[RADIUS][RADIUS];
    assign east   = win[RADIUS][LINES];
    assign north  = win[0][RADIUS];
    assign west   = win[RADIUS][0];
    assign south  = win[LINES][RADIUS];

    // Each cell brackets the sample point between floor and ceiling offsets.
    assign cellA[lbpPkg::ANG45]  = win[RADIUS-CL][RADIUS+FL];
    assign cellB[lbpPkg::ANG45]  = win[RADIUS-CL][RADIUS+CL];
    assign cellC[lbpPkg::ANG45]  = win[RADIUS-FL][RADIUS+FL];
    assign cellD[lbpPkg::ANG45]  = win[RADIUS-FL][RADIUS+CL];
    assign cellA[lbpPkg::ANG135] = win[RADIUS-CL][RADIUS-CL];
    assign cellB[lbpPkg::ANG135] = win[RADIUS-CL][RADIUS-FL];
    assign cellC[lbpPkg::ANG135] = win[RADIUS-FL][RADIUS-CL];
    assign cellD[lbpPkg::ANG135] = win[RADIUS-FL][RADIUS-FL];
    assign cellA[lbpPkg::ANG225] = win[RADIUS+FL][RADIUS-CL];
    assign cellB[lbpPkg::ANG225] = win[RADIUS+FL][RADIUS-FL];
    assign cellC[lbpPkg::ANG225] = win[RADIUS+CL][RADIUS-CL];
    assign cellD[lbpPkg::ANG225] = win[RADIUS+CL][RADIUS-FL];
    assign cellA[lbpPkg::ANG315] = win[RADIUS+FL][RADIUS+FL];
    assign cellB[lbpPkg::ANG315] = win[RADIUS+FL][RADIUS+CL];
    assign cellC[lbpPkg::ANG315] = win[RADIUS+CL][RADIUS+FL];
    assign cellD[lbpPkg::ANG315] = win[RADIUS+CL][RADIUS+CL];

endmodule

`default_nettype wire

// File: verilog/lbpController.sv
`default_nettype none

module lbpController (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  notEmpty,
    input  wire  interior,
    input  wire  lastPixel,
    input  wire  codeCredit,
    output logic pop,
    output logic frameDone
);

    localparam int CREDIT_W = 16;

    lbpPkg::ctrlState      state;
    logic [CREDIT_W-1:0]   creditCnt;
    logic                  takeCredit;

    // An interior pixel only leaves the FIFO with an output slot reserved,
    // so the pipeline behind it never has to stall.
    assign pop        = notEmpty && (state != lbpPkg::FRAME_END) &&
                        (!interior || (creditCnt != '0));
    assign takeCredit = pop && interior;
    assign frameDone  = (state == lbpPkg::FRAME_END);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= lbpPkg::FILL;
            creditCnt <= '0;
        end else begin
            creditCnt <= creditCnt + CREDIT_W'(codeCredit) - CREDIT_W'(takeCredit);
            case (state)
                lbpPkg::FILL: begin
                    if (pop && lastPixel) begin
                        state <= lbpPkg::FRAME_END;
                    end else if (takeCredit) begin
                        state <= lbpPkg::STREAM;   // First full neighbourhood.
                    end
                end
                lbpPkg::STREAM: begin
                    if (pop && lastPixel) begin
                        state <= lbpPkg::FRAME_END;
                    end
                end
                lbpPkg::FRAME_END: begin
                    state <= lbpPkg::FILL;         // Single pulse of frameDone.
                end
                default: begin
                    state <= lbpPkg::FILL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/scanCounter.sv
`default_nettype none

module scanCounter #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 12,
    parameter int RADIUS     = 2
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  advance,
    output logic interior,
    output logic lastPixel
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             endOfRow;

    // Position of the next pixel to be popped.
    assign endOfRow  = (col == COL_W'(IMG_WIDTH - 1));
    assign lastPixel = endOfRow && (row == ROW_W'(IMG_HEIGHT - 1));
    // This pixel fills the bottom-right of a window whose centre is RADIUS inside.
    assign interior  = (int'(col) >= 2 * RADIUS) && (int'(row) >= 2 * RADIUS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (advance) begin
            if (endOfRow) begin
                col <= '0;
                row <= lastPixel ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pixelFifo.sv
`default_nettype none

module pixelFifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       pixValid,
    input  wire [lbpPkg::PIX_W-1:0]   pixData,
    input  wire                       pop,
    output logic [lbpPkg::PIX_W-1:0]  headData,
    output logic                      notEmpty,
    output logic                      pixCredit
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [lbpPkg::PIX_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]         wrPtr;
    logic [PTR_W-1:0]         rdPtr;
    logic [CNT_W-1:0]         count;

    assign headData = mem[rdPtr];
    assign notEmpty = (count != '0);

    always_ff @(posedge clk) begin
        if (pixValid) begin
            mem[wrPtr] <= pixData;
        end
    end

    // The source never exceeds its credit, so a push always finds room.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            pixCredit <= 1'b0;
        end else begin
            if (pixValid) begin
                wrPtr <= (wrPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count     <= count + CNT_W'(pixValid) - CNT_W'(pop);
            pixCredit <= pop;   // One credit back per slot freed.
        end
    end

endmodule

`default_nettype wire

// File: verilog/lbpPkg.sv
`default_nettype none

package lbpPkg;

    localparam int PIX_W    = 8;
    localparam int WEIGHT_W = 24;

    typedef enum logic [1:0] {
        ANG45,
        ANG135,
        ANG225,
        ANG315
    } diagAngle;

    typedef enum logic [1:0] {
        FILL,
        STREAM,
        FRAME_END
    } ctrlState;

    // ******************************
    // Bilinear weights, Q0.16.
    // ******************************
    // The sample sits RADIUS*cos45 from the centre on both axes, so one fraction
    // serves both axes. The near corner is the one closest to the centre and gets
    // (1-f)^2, the opposite corner gets f^2, the other two get f*(1-f).
    function automatic logic [WEIGHT_W-1:0] weightOf(input int radius,
                                                     input diagAngle angle,
                                                     input int corner);
        logic [WEIGHT_W-1:0] wNear;
        logic [WEIGHT_W-1:0] wMix;
        logic [WEIGHT_W-1:0] wFar;
        int nearIdx;
        case (radius)
            2: {wNear, wMix, wFar} = {24'h0057D8, 24'h003E1D, 24'h002BEC};
            3: {wNear, wMix, wFar} = {24'h00C5A6, 24'h001B4A, 24'h0003C4};
            4: {wNear, wMix, wFar} = {24'h000789, 24'h002463, 24'h00AFB0};
            5: {wNear, wMix, wFar} = {24'h003739, 24'h003FAD, 24'h00496B};
            6: {wNear, wMix, wFar} = {24'h0092D6, 24'h002F0B, 24'h000F12};
            7: {wNear, wMix, wFar} = {24'h0000A5, 24'h000C37, 24'h00E6EA};
            8: {wNear, wMix, wFar} = {24'h001E24, 24'h0039B3, 24'h006E73};
            default: {wNear, wMix, wFar} = '0;   // Radius outside 2..8.
        endcase
        // Corners are A=0 top-left, B=1 top-right, C=2 bottom-left, D=3 bottom-right.
        case (angle)
            ANG45:   nearIdx = 2;
            ANG135:  nearIdx = 3;
            ANG225:  nearIdx = 1;
            default: nearIdx = 0;
        endcase
        if (corner == nearIdx) begin
            return wNear;
        end else if (corner == 3 - nearIdx) begin
            return wFar;                      // Diagonal opposite of the near corner.
        end
        return wMix;
    endfunction

endpackage

`default_nettype wire
